// ==== Bender.yml ====
package:
  name: npc

sources:
  - common/npc_pkg.sv
  - bus/axi_bus_fsm.sv
  - core/decode_exec.sv
  - core/reg_file.sv
  - hdl/lsu_align.sv
  - hdl/npc_top.sv
  - target: test
    files:
      - verification/tb_clock_gen.sv
      - verification/npc_bus_chk.sv
      - verification/tb_npc.sv

// ==== bus/axi_bus_fsm.sv ====
`timescale 1ns/1ps

module axi_bus_fsm (
    input  logic              clock,
    input  logic              reset,
    input  npc_pkg::mem_req_t mem_req,
    input  npc_pkg::axi_ar_t  load_ar,
    input  logic [31:0]       pc,
    output npc_pkg::axi_ar_t  ar,
    output logic              arvalid,
    output logic              awvalid,
    output logic              wvalid,
    output logic              rready,
    output logic              bready,
    input  logic              arready,
    input  logic              awready,
    input  logic              wready,
    input  logic              rvalid,
    input  npc_pkg::axi_r_t   r,
    output npc_pkg::inst_u    inst_word,
    output logic              fetch_done,
    output logic              exec,
    output logic              load_done
);
    import npc_pkg::*;

    logic [2:0] state;
    logic [2:0] next_state;
    logic       ar_fire;
    logic       r_fire;

    assign ar_fire = arvalid && arready;
    assign r_fire  = rvalid && rready;

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= st_idle;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state; // hold while the slave stalls.
        case (state)
            st_idle: begin
                next_state = st_ifu_ar;
            end
            st_ifu_ar: begin
                if (ar_fire) begin
                    next_state = st_ifu_r;
                end
            end
            st_ifu_r: begin
                if (r_fire) begin
                    next_state = st_exeu;
                end
            end
            st_exeu: begin
                if (mem_req.wen) begin
                    next_state = st_lsu_aw;
                end else if (mem_req.ren) begin
                    next_state = st_lsu_ar;
                end else begin
                    next_state = st_ifu_ar;
                end
            end
            st_lsu_aw: begin
                if (awvalid && awready) begin
                    next_state = st_lsu_w;
                end
            end
            st_lsu_w: begin
                if (wvalid && wready) begin
                    next_state = st_ifu_ar;
                end
            end
            st_lsu_ar: begin
                if (ar_fire) begin
                    next_state = st_lsu_r;
                end
            end
            st_lsu_r: begin
                if (r_fire) begin
                    next_state = st_ifu_ar;
                end
            end
            default: begin
                next_state = st_idle;
            end
        endcase
    end

    assign arvalid = (state == st_ifu_ar) || (state == st_lsu_ar);
    assign awvalid = (state == st_lsu_aw);
    assign wvalid  = (state == st_lsu_w);
    assign rready  = (state == st_ifu_r) || (state == st_lsu_r);
    assign bready  = 1'b1; // write responses are accepted and dropped.

    // instruction fetches are always single word reads at pc.
    always_comb begin
        if (state == st_ifu_ar) begin
            ar.addr  = pc;
            ar.id    = 4'd0;
            ar.len   = 8'd0;
            ar.size  = {1'b0, size_word};
            ar.burst = burst_incr;
        end else begin
            ar = load_ar;
        end
    end

    always_ff @(posedge clock) begin
        if (state == st_ifu_r && r_fire) begin
            inst_word <= r.data;
        end
    end

    assign fetch_done = (state == st_ifu_r) && r_fire;
    assign exec       = (state == st_exeu);
    assign load_done  = (state == st_lsu_r) && r_fire;

endmodule

// ==== common/npc_pkg.sv ====
package npc_pkg;

    localparam logic [31:0] reset_pc = 32'h0000_0000;

    // rv32i major opcodes for the supported subset.
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_reg    = 7'b0110011;

    localparam logic [2:0] st_idle   = 3'd0;
    localparam logic [2:0] st_ifu_ar = 3'd1;
    localparam logic [2:0] st_ifu_r  = 3'd2;
    localparam logic [2:0] st_exeu   = 3'd3;
    localparam logic [2:0] st_lsu_aw = 3'd4;
    localparam logic [2:0] st_lsu_w  = 3'd5;
    localparam logic [2:0] st_lsu_ar = 3'd6;
    localparam logic [2:0] st_lsu_r  = 3'd7;

    localparam logic [1:0] size_byte  = 2'd0; // same as funct3[1:0] of loads and stores.
    localparam logic [1:0] size_half  = 2'd1;
    localparam logic [1:0] size_word  = 2'd2;
    localparam logic [1:0] burst_incr = 2'b01;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    // one instruction word, seen through each encoding format.
    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        s_fmt_t s_fmt;
        b_fmt_t b_fmt;
        u_fmt_t u_fmt;
        j_fmt_t j_fmt;
    } inst_u;

    typedef struct packed {
        logic        wen;
        logic        ren;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [1:0]  size;
    } mem_req_t;

    typedef struct packed {
        logic [31:0] addr;
        logic [3:0]  id;
        logic [7:0]  len;
        logic [2:0]  size;
        logic [1:0]  burst;
    } axi_ar_t;

    typedef axi_ar_t axi_aw_t;

    typedef struct packed {
        logic [31:0] data;
        logic [3:0]  strb;
        logic        last;
    } axi_w_t;

    typedef struct packed {
        logic [31:0] data;
        logic [1:0]  resp;
        logic        last;
        logic [3:0]  id;
    } axi_r_t;

    typedef struct packed {
        logic [1:0] resp;
        logic [3:0] id;
    } axi_b_t;

endpackage

// ==== core/decode_exec.sv ====
`timescale 1ns/1ps

module decode_exec (
    input  logic              clock,
    input  logic              reset,
    input  npc_pkg::inst_u    inst_word,
    input  logic              fetch_done,
    input  logic              exec,
    input  logic              load_done,
    input  logic [31:0]       rs1_data,
    input  logic [31:0]       rs2_data,
    input  logic [31:0]       load_data,
    output logic [31:0]       pc,
    output npc_pkg::mem_req_t mem_req,
    output logic [4:0]        rs1_addr,
    output logic [4:0]        rs2_addr,
    output logic [4:0]        rd_addr,
    output logic [31:0]       rd_data,
    output logic              rd_we
);
    import npc_pkg::*;

    logic [6:0]  opcode;
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] imm_b;
    logic [31:0] imm_u;
    logic [31:0] imm_j;
    logic        is_load;
    logic        is_store;
    logic        writes_rd;
    logic        branch_taken;
    logic        inst_valid;
    logic [31:0] pc_plus4;
    logic [31:0] next_pc;
    logic [31:0] alu_result;

    assign opcode   = inst_word.r_fmt.opcode;
    assign rs1_addr = inst_word.r_fmt.rs1;
    assign rs2_addr = inst_word.r_fmt.rs2;
    assign rd_addr  = inst_word.r_fmt.rd;

    assign imm_i = {{20{inst_word.i_fmt.imm[11]}}, inst_word.i_fmt.imm};
    assign imm_s = {{20{inst_word.s_fmt.imm_hi[6]}}, inst_word.s_fmt.imm_hi,
                    inst_word.s_fmt.imm_lo};
    assign imm_b = {{19{inst_word.b_fmt.imm12}}, inst_word.b_fmt.imm12,
                    inst_word.b_fmt.imm11, inst_word.b_fmt.imm10_5,
                    inst_word.b_fmt.imm4_1, 1'b0};
    assign imm_u = {inst_word.u_fmt.imm, 12'd0};
    assign imm_j = {{11{inst_word.j_fmt.imm20}}, inst_word.j_fmt.imm20,
                    inst_word.j_fmt.imm19_12, inst_word.j_fmt.imm11,
                    inst_word.j_fmt.imm10_1, 1'b0};

    assign is_load   = (opcode == op_load);
    assign is_store  = (opcode == op_store);
    assign writes_rd = (opcode == op_lui) || (opcode == op_imm) ||
                       (opcode == op_reg) || (opcode == op_jal);

    assign pc_plus4 = pc + 32'd4;

    // funct3 bit 0 separates bne from beq.
    assign branch_taken = inst_word.b_fmt.funct3[0] ? (rs1_data != rs2_data)
                                                    : (rs1_data == rs2_data);

    always_comb begin
        case (opcode)
            op_lui:  alu_result = imm_u;
            op_imm:  alu_result = rs1_data + imm_i;
            op_reg:  alu_result = inst_word.r_fmt.funct7[5] ? rs1_data - rs2_data
                                                            : rs1_data + rs2_data;
            op_jal:  alu_result = pc_plus4; // link address.
            default: alu_result = 32'd0;
        endcase
    end

    always_comb begin
        next_pc = pc_plus4;
        if (opcode == op_jal) begin
            next_pc = pc + imm_j;
        end else if (opcode == op_branch && branch_taken) begin
            next_pc = pc + imm_b;
        end
    end

    // the held word only counts as an instruction between its fetch and retirement.
    always_ff @(posedge clock) begin
        if (reset) begin
            inst_valid <= 1'b0;
        end else if (fetch_done) begin
            inst_valid <= 1'b1;
        end else if (load_done || (exec && !is_load)) begin
            inst_valid <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            pc <= reset_pc;
        end else if (exec) begin
            pc <= next_pc;
        end
    end

    always_comb begin
        mem_req.wen   = inst_valid && is_store;
        mem_req.ren   = inst_valid && is_load;
        mem_req.addr  = rs1_data + (is_store ? imm_s : imm_i);
        mem_req.wdata = rs2_data;
        mem_req.size  = inst_word.i_fmt.funct3[1:0];
    end

    assign rd_we   = inst_valid && ((exec && writes_rd) || (load_done && is_load));
    assign rd_data = is_load ? load_data : alu_result;

endmodule

// ==== core/reg_file.sv ====
`timescale 1ns/1ps

module reg_file (
    input  logic        clock,
    input  logic        reset,
    input  logic [4:0]  rs1_addr,
    input  logic [4:0]  rs2_addr,
    input  logic [4:0]  rd_addr,
    input  logic [31:0] rd_data,
    input  logic        rd_we,
    output logic [31:0] rs1_data,
    output logic [31:0] rs2_data
);

    logic [31:0] regs [1:31]; // x0 has no storage.

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= 32'd0;
            end
        end else if (rd_we && rd_addr != 5'd0) begin
            regs[rd_addr] <= rd_data;
        end
    end

    assign rs1_data = (rs1_addr == 5'd0) ? 32'd0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == 5'd0) ? 32'd0 : regs[rs2_addr];

endmodule

// ==== hdl/lsu_align.sv ====
`timescale 1ns/1ps

module lsu_align (
    input  npc_pkg::mem_req_t mem_req,
    input  npc_pkg::axi_r_t   r,
    output npc_pkg::axi_aw_t  aw,
    output npc_pkg::axi_w_t   w,
    output npc_pkg::axi_ar_t  load_ar,
    output logic [31:0]       load_data
);
    import npc_pkg::*;

    logic [3:0]  base_strb;
    logic [31:0] lane_data;
    logic [31:0] shifted;

    always_comb begin
        case (mem_req.size)
            size_byte: begin
                base_strb = 4'b0001;
                lane_data = {4{mem_req.wdata[7:0]}};
            end
            size_half: begin
                base_strb = 4'b0011;
                lane_data = {2{mem_req.wdata[15:0]}};
            end
            default: begin
                base_strb = 4'b1111;
                lane_data = mem_req.wdata;
            end
        endcase
    end

    always_comb begin
        aw.addr  = mem_req.addr;
        aw.id    = 4'd0;
        aw.len   = 8'd0;
        aw.size  = {1'b0, mem_req.size};
        aw.burst = burst_incr;
        load_ar  = aw; // loads and stores share address and size.
        w.data   = lane_data;
        w.strb   = base_strb << mem_req.addr[1:0];
        w.last   = 1'b1;
    end

    // the slave returns the whole word, so move the addressed lane down.
    assign shifted = r.data >> {mem_req.addr[1:0], 3'b000};

    always_comb begin
        case (mem_req.size)
            size_byte: load_data = {24'd0, shifted[7:0]};
            size_half: load_data = {16'd0, shifted[15:0]};
            default:   load_data = shifted;
        endcase
    end

endmodule

// ==== hdl/npc_top.sv ====
`timescale 1ns/1ps

module npc_top (
    input  logic             clock,
    input  logic             reset,
    output npc_pkg::axi_ar_t ar,
    output logic             arvalid,
    input  logic             arready,
    input  npc_pkg::axi_r_t  r,
    input  logic             rvalid,
    output logic             rready,
    output npc_pkg::axi_aw_t aw,
    output logic             awvalid,
    input  logic             awready,
    output npc_pkg::axi_w_t  w,
    output logic             wvalid,
    input  logic             wready,
    input  npc_pkg::axi_b_t  b,
    input  logic             bvalid,
    output logic             bready
);
    import npc_pkg::*;

    mem_req_t    mem_req;
    axi_ar_t     load_ar;
    inst_u       inst_word;
    logic [31:0] pc;
    logic [31:0] load_data;
    logic        fetch_done;
    logic        exec;
    logic        load_done;
    logic [4:0]  rs1_addr;
    logic [4:0]  rs2_addr;
    logic [4:0]  rd_addr;
    logic [31:0] rd_data;
    logic        rd_we;
    logic [31:0] rs1_data;
    logic [31:0] rs2_data;

    axi_bus_fsm u_bus (
        .clock(clock), .reset(reset), .mem_req(mem_req), .load_ar(load_ar), .pc(pc),
        .ar(ar), .arvalid(arvalid), .awvalid(awvalid), .wvalid(wvalid), .rready(rready),
        .bready(bready), .arready(arready), .awready(awready), .wready(wready),
        .rvalid(rvalid), .r(r), .inst_word(inst_word), .fetch_done(fetch_done),
        .exec(exec), .load_done(load_done)
    );

    decode_exec u_core (
        .clock(clock), .reset(reset), .inst_word(inst_word), .fetch_done(fetch_done),
        .exec(exec), .load_done(load_done), .rs1_data(rs1_data), .rs2_data(rs2_data),
        .load_data(load_data), .pc(pc), .mem_req(mem_req), .rs1_addr(rs1_addr),
        .rs2_addr(rs2_addr), .rd_addr(rd_addr), .rd_data(rd_data), .rd_we(rd_we)
    );

    reg_file u_regs (
        .clock(clock), .reset(reset), .rs1_addr(rs1_addr), .rs2_addr(rs2_addr),
        .rd_addr(rd_addr), .rd_data(rd_data), .rd_we(rd_we),
        .rs1_data(rs1_data), .rs2_data(rs2_data)
    );

    lsu_align u_align (
        .mem_req(mem_req), .r(r), .aw(aw), .w(w), .load_ar(load_ar), .load_data(load_data)
    );

endmodule

// ==== verification/npc_bus_chk.sv ====
`timescale 1ns/1ps

module npc_bus_chk (
    input logic              clock,
    input logic              reset,
    input logic [2:0]        state,
    input npc_pkg::axi_ar_t  ar,
    input npc_pkg::mem_req_t mem_req,
    input logic              arvalid,
    input logic              arready,
    input logic              awvalid,
    input logic              awready,
    input logic              wvalid,
    input logic              wready,
    input logic              rvalid,
    input logic              rready
);
    import npc_pkg::*;

    int fail_count = 0;

    ar_held: assert property (@(posedge clock) disable iff (reset)
        arvalid && !arready |=> arvalid && $stable(ar))
        else begin
            fail_count++;
            $error("arvalid dropped or ar changed before its transfer");
        end

    // aw and w payloads come straight from the memory request.
    aw_held: assert property (@(posedge clock) disable iff (reset)
        awvalid && !awready |=> awvalid && $stable({mem_req.addr, mem_req.size}))
        else begin
            fail_count++;
            $error("awvalid dropped or the write address changed before its transfer");
        end

    w_held: assert property (@(posedge clock) disable iff (reset)
        wvalid && !wready |=> wvalid && $stable({mem_req.addr, mem_req.wdata, mem_req.size}))
        else begin
            fail_count++;
            $error("wvalid dropped or the write data changed before its transfer");
        end

    r_held: assert property (@(posedge clock) disable iff (reset)
        rready && !rvalid |=> rready)
        else begin
            fail_count++;
            $error("rready dropped before the read data arrived");
        end

    aw_w_apart: assert property (@(posedge clock) disable iff (reset)
        !(awvalid && wvalid))
        else begin
            fail_count++;
            $error("awvalid and wvalid were high together");
        end

    one_valid: assert property (@(posedge clock) disable iff (reset)
        $onehot0({arvalid, awvalid, wvalid}))
        else begin
            fail_count++;
            $error("more than one address or write valid was high");
        end

    exec_single: assert property (@(posedge clock) disable iff (reset)
        state == st_exeu |=> state != st_exeu)
        else begin
            fail_count++;
            $error("the execute state lasted more than one cycle");
        end

    reset_quiet: assert property (@(posedge clock)
        $past(reset) |-> !(arvalid || awvalid || wvalid || rready))
        else begin
            fail_count++;
            $error("a valid or rready was high during reset or the cycle after it");
        end

    first_fetch: assert property (@(posedge clock)
        $fell(reset) |-> !arvalid ##1 arvalid)
        else begin
            fail_count++;
            $error("the first fetch did not start on the second cycle after reset");
        end

endmodule

bind axi_bus_fsm npc_bus_chk bus_chk (
    .clock(clock), .reset(reset), .state(state), .ar(ar), .mem_req(mem_req),
    .arvalid(arvalid), .arready(arready), .awvalid(awvalid), .awready(awready),
    .wvalid(wvalid), .wready(wready), .rvalid(rvalid), .rready(rready)
);

// ==== verification/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clock,
    output logic reset
);

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    initial begin
        reset = 1'b1;
        repeat (2) @(posedge clock);
        reset <= 1'b0; // released on a rising edge like the other stimulus.
    end

endmodule

// ==== verification/tb_npc.sv ====
`timescale 1ns/1ps

module tb_npc;
    import npc_pkg::*;

    localparam int          prog_len   = 64;
    localparam int          data_base  = 32'h400;
    localparam int          max_cycles = prog_len * 40 + 100;
    localparam logic [31:0] last_pc    = reset_pc + 32'((prog_len - 1) * 4);

    logic    clock;
    logic    reset;
    axi_ar_t ar;
    logic    arvalid;
    logic    arready;
    axi_r_t  r;
    logic    rvalid;
    logic    rready;
    axi_aw_t aw;
    logic    awvalid;
    logic    awready;
    axi_w_t  w;
    logic    wvalid;
    logic    wready;
    axi_b_t  b;
    logic    bvalid;
    logic    bready;

    logic [31:0] mem [0:1023];     // slave memory seen by the DUT.
    logic [31:0] ref_mem [0:1023]; // memory of the ISA model.
    logic [31:0] xreg [0:31];
    logic [31:0] lfsr;
    logic [31:0] model_pc;
    logic [31:0] exp_addr;
    logic [31:0] exp_wdata;
    logic [3:0]  exp_strb;
    logic [1:0]  exp_size;
    logic        load_pending;
    logic        store_pending;
    logic        finished;
    logic [31:0] rd_addr_q;
    logic [31:0] wr_addr_q;
    logic        r_pending;
    int          end_fetches;
    int          errors;
    int          chk_fails;
    int          cycles = 0;

    tb_clock_gen clock_gen (.clock(clock), .reset(reset));

    npc_top UUT (
        .clock(clock), .reset(reset), .ar(ar), .arvalid(arvalid), .arready(arready),
        .r(r), .rvalid(rvalid), .rready(rready), .aw(aw), .awvalid(awvalid),
        .awready(awready), .w(w), .wvalid(wvalid), .wready(wready), .b(b),
        .bvalid(bvalid), .bready(bready)
    );

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic logic [31:0] merge_bytes(input logic [31:0] old,
                                                input logic [31:0] data,
                                                input logic [3:0]  strb);
        logic [31:0] v;
        v = old;
        for (int i = 0; i < 4; i++) begin
            if (strb[i]) begin
                v[i*8 +: 8] = data[i*8 +: 8];
            end
        end
        return v;
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("ERR %s expected %08h actual %08h at %0t", name, expected, actual, $time);
        errors++;
    endtask

    task automatic report_failure(input string what);
        $display("%s at %0t", what, $time);
        errors++;
    endtask

    // branches and jumps only go forward, so every run reaches the final loop.
    task automatic build_program();
        logic [3:0]  kind;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [11:0] imm;
        logic [20:0] off;
        int          span;
        mem[0] = {12'(data_base), 5'd0, 3'b000, 5'd1, op_imm};
        for (int k = 1; k < prog_len - 1; k++) begin
            kind = rand_bits(4);
            rd   = rand_bits(5);
            rs1  = rand_bits(5);
            rs2  = rand_bits(5);
            imm  = rand_bits(12);
            if (rd == 5'd1) begin
                rd = 5'd0; // x1 keeps the data base.
            end
            span = (prog_len - 1 - k > 8) ? 8 : prog_len - 1 - k;
            off  = 21'((1 + rand_bits(8) % span) * 4);
            case (kind)
                4'd0:              mem[k] = {imm, rs1, rs2[2:0], rd, op_lui};
                4'd1, 4'd2, 4'd15: mem[k] = {imm, rs1, 3'b000, rd, op_imm};
                4'd3:              mem[k] = {7'b0000000, rs2, rs1, 3'b000, rd, op_reg};
                4'd4:              mem[k] = {7'b0100000, rs2, rs1, 3'b000, rd, op_reg};
                4'd5, 4'd6: begin
                    mem[k] = {off[12], off[10:5], rs2, rs1, 2'b00, ~kind[0], off[4:1],
                              off[11], op_branch};
                end
                4'd7:  mem[k] = {off[20], off[10:1], off[11], off[19:12], rd, op_jal};
                4'd8:  mem[k] = {4'd0, imm[7:2], 2'b00, 5'd1, 3'b010, rd, op_load};
                4'd9:  mem[k] = {4'd0, imm[7:1], 1'b0, 5'd1, 3'b101, rd, op_load};
                4'd10: mem[k] = {4'd0, imm[7:0], 5'd1, 3'b100, rd, op_load};
                4'd11, 4'd12: begin
                    mem[k] = {4'd0, imm[7:5], rs2, 5'd1, 3'b010, imm[4:2], 2'b00, op_store};
                end
                4'd13: mem[k] = {4'd0, imm[7:5], rs2, 5'd1, 3'b001, imm[4:1], 1'b0, op_store};
                default: mem[k] = {4'd0, imm[7:5], rs2, 5'd1, 3'b000, imm[4:0], op_store};
            endcase
        end
        mem[prog_len - 1] = {20'd0, 5'd0, op_jal}; // jumps to itself.
    endtask

    task automatic model_step();
        logic [31:0] inst;
        logic [31:0] src1;
        logic [31:0] src2;
        logic [31:0] imm_i;
        logic [31:0] next_pc;
        logic [31:0] word;
        logic [4:0]  rd;
        inst    = ref_mem[model_pc[11:2]];
        rd      = inst[11:7];
        src1    = xreg[inst[19:15]];
        src2    = xreg[inst[24:20]];
        imm_i   = {{20{inst[31]}}, inst[31:20]};
        next_pc = model_pc + 32'd4;
        case (inst[6:0])
            op_lui: xreg[rd] = {inst[31:12], 12'd0};
            op_imm: xreg[rd] = src1 + imm_i;
            op_reg: xreg[rd] = inst[30] ? src1 - src2 : src1 + src2;
            op_jal: begin
                xreg[rd] = model_pc + 32'd4;
                next_pc  = model_pc + {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
            end
            op_branch: begin
                if ((src1 == src2) != inst[12]) begin // funct3 bit 0 marks bne.
                    next_pc = model_pc + {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
                end
            end
            op_load: begin
                exp_addr     = src1 + imm_i;
                exp_size     = inst[13:12];
                word         = ref_mem[exp_addr[11:2]] >> {exp_addr[1:0], 3'b000};
                case (exp_size)
                    2'd0:    xreg[rd] = {24'd0, word[7:0]};
                    2'd1:    xreg[rd] = {16'd0, word[15:0]};
                    default: xreg[rd] = word;
                endcase
                load_pending = 1'b1;
            end
            op_store: begin
                exp_addr = src1 + {{20{inst[31]}}, inst[31:25], inst[11:7]};
                exp_size = inst[13:12];
                case (exp_size)
                    2'd0: begin
                        exp_strb  = 4'b0001;
                        exp_wdata = {4{src2[7:0]}};
                    end
                    2'd1: begin
                        exp_strb  = 4'b0011;
                        exp_wdata = {2{src2[15:0]}};
                    end
                    default: begin
                        exp_strb  = 4'b1111;
                        exp_wdata = src2;
                    end
                endcase
                exp_strb = exp_strb << exp_addr[1:0];
                ref_mem[exp_addr[11:2]] = merge_bytes(ref_mem[exp_addr[11:2]], exp_wdata,
                                                      exp_strb);
                store_pending = 1'b1;
            end
        endcase
        xreg[0]  = 32'd0;
        model_pc = next_pc;
    endtask

    // AXI slave with random ready and rvalid delays.
    always @(posedge clock) begin
        if (reset) begin
            arready   <= 1'b0;
            awready   <= 1'b0;
            wready    <= 1'b0;
            rvalid    <= 1'b0;
            r_pending <= 1'b0;
        end else begin
            arready <= rand_bits(1);
            awready <= rand_bits(1);
            wready  <= rand_bits(1);
            if (arvalid && arready) begin
                rd_addr_q <= ar.addr;
                r_pending <= 1'b1;
            end
            if (rvalid && rready) begin
                rvalid <= 1'b0;
            end else if (r_pending && !rvalid && rand_bits(1)) begin
                rvalid    <= 1'b1;
                r.data    <= mem[rd_addr_q[11:2]];
                r_pending <= 1'b0;
            end
            if (awvalid && awready) begin
                wr_addr_q <= aw.addr;
            end
            if (wvalid && wready) begin
                mem[wr_addr_q[11:2]] = merge_bytes(mem[wr_addr_q[11:2]], w.data, w.strb);
            end
        end
    end

    always @(posedge clock) begin
        if (!reset && !finished) begin
            if (bready !== 1'b1) begin
                report_mismatch("bready", 32'd1, bready);
            end
            if (arvalid && arready) begin
                if ({ar.id, ar.len} !== 12'd0) begin
                    report_mismatch("arid arlen", 32'd0, {ar.id, ar.len});
                end
                if (load_pending) begin
                    if (ar.addr !== exp_addr) begin
                        report_mismatch("load araddr", exp_addr, ar.addr);
                    end
                    if (ar.size !== {1'b0, exp_size}) begin
                        report_mismatch("load arsize", {1'b0, exp_size}, ar.size);
                    end
                    load_pending = 1'b0;
                end else begin
                    if (store_pending) begin
                        report_failure("a fetch started before the store finished");
                    end
                    if (ar.addr !== model_pc) begin
                        report_mismatch("fetch araddr", model_pc, ar.addr);
                    end
                    if (ar.size !== 3'd2) begin
                        report_mismatch("fetch arsize", 32'd2, ar.size);
                    end
                    if (model_pc == last_pc) begin
                        end_fetches++;
                    end
                    if (end_fetches == 2) begin
                        finished = 1'b1;
                    end else begin
                        model_step();
                    end
                end
            end
            if (awvalid && awready) begin
                if (!store_pending) begin
                    report_failure("a write address appeared without a store");
                end
                if ({aw.id, aw.len} !== 12'd0) begin
                    report_mismatch("awid awlen", 32'd0, {aw.id, aw.len});
                end
                if (aw.addr !== exp_addr) begin
                    report_mismatch("store awaddr", exp_addr, aw.addr);
                end
                if (aw.size !== {1'b0, exp_size}) begin
                    report_mismatch("store awsize", {1'b0, exp_size}, aw.size);
                end
            end
            if (wvalid && wready) begin
                if (w.data !== exp_wdata) begin
                    report_mismatch("store wdata", exp_wdata, w.data);
                end
                if (w.strb !== exp_strb) begin
                    report_mismatch("store wstrb", exp_strb, w.strb);
                end
                if (w.last !== 1'b1) begin
                    report_mismatch("store wlast", 32'd1, w.last);
                end
                store_pending = 1'b0;
            end
        end
    end

    always @(posedge clock) begin
        if (!reset) begin
            cycles <= cycles + 1;
        end
    end

    initial begin
        lfsr          = 32'hfd00afc9;
        errors        = 0;
        end_fetches   = 0;
        finished      = 1'b0;
        load_pending  = 1'b0;
        store_pending = 1'b0;
        model_pc      = reset_pc;
        arready       <= 1'b0;
        awready       <= 1'b0;
        wready        <= 1'b0;
        rvalid        <= 1'b0;
        bvalid        <= 1'b0;
        r             <= '{data: 32'd0, resp: 2'd0, last: 1'b1, id: 4'd0};
        b             <= '0;
        for (int i = 0; i < 1024; i++) begin
            mem[i] = (i * 32'h9e37_79b1) ^ 32'h5a5a_0f0f;
        end
        build_program();
        for (int i = 0; i < 1024; i++) begin
            ref_mem[i] = mem[i];
        end
        for (int i = 0; i < 32; i++) begin
            xreg[i] = 32'd0;
        end
        while (!finished && cycles < max_cycles) begin
            @(posedge clock);
        end
        if (finished) begin
            for (int i = data_base / 4; i < data_base / 4 + 64; i++) begin
                if (mem[i] !== ref_mem[i]) begin
                    report_mismatch("data memory", ref_mem[i], mem[i]);
                end
            end
        end else begin
            report_failure("timeout, the program never reached its final loop");
        end
        chk_fails = UUT.u_bus.bus_chk.fail_count;
        $display("cycles %0d, check errors %0d, assertion failures %0d",
                 cycles, errors, chk_fails);
        if (errors == 0 && chk_fails == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
common/npc_pkg.sv
bus/axi_bus_fsm.sv
core/decode_exec.sv
core/reg_file.sv
hdl/lsu_align.sv
hdl/npc_top.sv
verification/tb_clock_gen.sv
verification/npc_bus_chk.sv
verification/tb_npc.sv
